// File: sources.f
common/sad_pkg.sv
hdl/usb_reg_bus.sv
sad/sad_ref_regs.sv
sad/sad_engine.sv
hdl/sad_trigger_top.sv
tests/sad_trigger_checker.sv
tests/sad_trigger_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SAD trigger testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module sad_trigger_tb -o sad_trigger_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sad_trigger_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: tests/sad_trigger_tb.sv
`default_nettype none

module sad_trigger_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_rows = 6;
  localparam int reset_cycles = 16;
  localparam int timeout_cycles = num_rows * 400 + reset_cycles;
  localparam int flat_bits = sad_pkg::ref_samples * sad_pkg::sample_bits;
  localparam int sb = sad_pkg::sample_bits;

  // Sample sets with sample 0 in the low bits
  localparam logic [flat_bits-1:0] match_ref =
    {12'h7FF, 12'h001, 12'hABC, 12'h789, 12'h456, 12'h123, 12'h800, 12'hFFF};
  localparam logic [flat_bits-1:0] ramp_ref =
    {12'd800, 12'd700, 12'd600, 12'd500, 12'd400, 12'd300, 12'd200, 12'd100};
  // SAD against ramp_ref is 50
  localparam logic [flat_bits-1:0] ramp_win =
    {12'd800, 12'd720, 12'd600, 12'd495, 12'd405, 12'd300, 12'd190, 12'd110};

  logic                            clk_usb;
  logic                            rst;
  logic [7:0]                      usb_addr;
  logic [7:0]                      usb_din;
  logic                            usb_rdn;
  logic                            usb_wrn;
  logic                            usb_cen;
  logic                            usb_alen;
  logic [sad_pkg::sample_bits-1:0] adc_data;
  logic                            sample_strobe;
  logic                            arm;
  logic [7:0]                      usb_dout;
  logic                            usb_isout;
  logic                            trigger;
  int                              error_count;

  // Stimulus table
  string                row_name  [num_rows];
  logic [flat_bits-1:0] row_ref   [num_rows];
  logic [15:0]          row_thr   [num_rows];
  logic [flat_bits-1:0] row_win   [num_rows];
  bit                   row_armed [num_rows];
  bit                   row_trig  [num_rows];

  integer seed = 32'hde8c_447c;
  int     cycle_count = 0;
  int     table_errors = 0;

  sad_trigger_top dut_i (.*);

  sad_trigger_checker checker_i (.*);

  initial begin
    clk_usb = 1'b0;
    forever #5 clk_usb = ~clk_usb;
  end

  // Run limit from the row count
  always @(posedge clk_usb) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Wait n edges and step 1 ns past the last one
  task automatic tick(input int n);
    repeat (n) @(posedge clk_usb);
    #1;
  endtask

  task automatic set_address(input logic [7:0] addr);
    usb_addr = addr;
    usb_cen  = 1'b0;
    usb_alen = 1'b0;
    tick(1);
    usb_alen = 1'b1;
    tick(1);
  endtask

  task automatic write_byte(input logic [7:0] data);
    usb_din = data;
    usb_wrn = 1'b0;
    tick(2);
    usb_wrn = 1'b1;
    tick(2);
  endtask

  // Strobe low for 4 cycles with data checked in the last one
  task automatic read_byte(input string what, input logic [7:0] exp);
    usb_rdn = 1'b0;
    tick(3);
    checker_i.check_dout(what, exp);
    tick(1);
    usb_rdn = 1'b1;
    tick(2);
  endtask

  task automatic pulse_arm();
    arm = 1'b1;
    tick(1);
    arm = 1'b0;
    tick(1);
  endtask

  // One strobed sample and a random gap of 0 to 3 cycles
  task automatic push_sample(input logic [sad_pkg::sample_bits-1:0] s);
    int gap;
    adc_data      = s;
    sample_strobe = 1'b1;
    tick(1);
    sample_strobe = 1'b0;
    gap = $random(seed) & 3;
    if (gap > 0) tick(gap);
  endtask

  task automatic set_row(input int r, input string name, input logic [flat_bits-1:0] refs,
                         input logic [15:0] thr, input logic [flat_bits-1:0] win,
                         input bit armed, input bit trig);
    row_name[r]  = name;
    row_ref[r]   = refs;
    row_thr[r]   = thr;
    row_win[r]   = win;
    row_armed[r] = armed;
    row_trig[r]  = trig;
  endtask

  initial begin
    logic [sad_pkg::sample_bits-1:0] smp;
    int w;
    int rv;
    int sad;
    bit armed_model;
    bit trig_model;
    bit exp_trig;
    armed_model   = 1'b0;
    trig_model    = 1'b0;
    rst           = 1'b1;
    usb_addr      = 8'h00;
    usb_din       = 8'h00;
    // Host read stays active through reset while usb_isout must stay low
    usb_rdn       = 1'b0;
    usb_wrn       = 1'b1;
    usb_cen       = 1'b0;
    usb_alen      = 1'b1;
    adc_data      = '0;
    sample_strobe = 1'b0;
    arm           = 1'b0;
    set_row(0, "unarmed_at_start", match_ref, 16'd0, match_ref, 1'b0, 1'b0);
    set_row(1, "exact_match", match_ref, 16'd0, match_ref, 1'b1, 1'b1);
    set_row(2, "no_second_shot", match_ref, 16'd0, match_ref, 1'b0, 1'b0);
    set_row(3, "sad_at_threshold", ramp_ref, 16'd50, ramp_win, 1'b1, 1'b1);
    set_row(4, "threshold_minus_one", ramp_ref, 16'd49, ramp_win, 1'b1, 1'b0);
    set_row(5, "full_scale_sum", '0, 16'hFFFF, {8{12'hFFF}}, 1'b1, 1'b1);
    tick(reset_cycles);
    rst     = 1'b0;
    usb_rdn = 1'b1;
    usb_cen = 1'b1;
    tick(2);
    for (int r = 0; r < num_rows; r++) begin
      checker_i.start_row();
      // Reference burst with the pad bits written as ones
      set_address(sad_pkg::reg_addr_ref);
      for (int i = 0; i < sad_pkg::ref_samples; i++) begin
        smp = row_ref[r][i*sb +: sb];
        write_byte(smp[7:0]);
        write_byte({4'hF, smp[11:8]});
      end
      set_address(sad_pkg::reg_addr_threshold);
      write_byte(row_thr[r][7:0]);
      write_byte(row_thr[r][15:8]);
      // Readback bursts where the pad bits read as zero
      set_address(sad_pkg::reg_addr_ref);
      for (int i = 0; i < sad_pkg::ref_samples; i++) begin
        smp = row_ref[r][i*sb +: sb];
        read_byte($sformatf("ref %0d lo", i), smp[7:0]);
        read_byte($sformatf("ref %0d hi", i), {4'h0, smp[11:8]});
      end
      set_address(sad_pkg::reg_addr_threshold);
      read_byte("threshold lo", row_thr[r][7:0]);
      read_byte("threshold hi", row_thr[r][15:8]);
      // Trigger expected when armed and SAD at or below threshold
      sad = 0;
      for (int i = 0; i < sad_pkg::ref_samples; i++) begin
        w   = int'(row_win[r][i*sb +: sb]);
        rv  = int'(row_ref[r][i*sb +: sb]);
        sad += (w > rv) ? w - rv : rv - w;
      end
      if (row_armed[r]) begin
        armed_model = 1'b1;
        trig_model  = 1'b0;
      end
      exp_trig = armed_model && (sad <= int'(row_thr[r]));
      if (exp_trig) begin
        armed_model = 1'b0;
        trig_model  = 1'b1;
      end
      if (exp_trig != row_trig[r]) begin
        $display("Table row %s lists trigger %0d but its SAD of %0d gives %0d",
                 row_name[r], row_trig[r], sad, exp_trig);
        table_errors++;
      end
      if (row_armed[r]) pulse_arm();
      for (int i = 0; i < sad_pkg::ref_samples; i++) begin
        push_sample(row_win[r][i*sb +: sb]);
      end
      tick(4);
      set_address(sad_pkg::reg_addr_status);
      read_byte("status", {6'b0, trig_model, armed_model});
      checker_i.finish_row(row_name[r], exp_trig ? 1 : 0);
    end
    checker_i.report();
    if (error_count == 0 && table_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/sad_trigger_checker.sv
`default_nettype none

module sad_trigger_checker (
  input  logic       clk_usb,
  input  logic       rst,
  input  logic       trigger,
  input  logic [7:0] usb_dout,
  input  logic       usb_isout,
  output int         error_count
);
  timeunit 1ns;
  timeprecision 1ps;

  // Trigger pulses since time zero, and the count when the row began
  int   trig_total = 0;
  int   trig_base = 0;
  // Reset errors come from the clocked watcher, the rest from the tasks
  int   reset_errors = 0;
  int   check_errors = 0;
  int   err_base = 0;
  int   rows_run = 0;
  int   rows_failed = 0;
  logic rst_q;

  assign error_count = reset_errors + check_errors;

  always @(posedge clk_usb) begin
    rst_q <= rst;
    if (rst_q === 1'b1) begin
      // Outputs stay low in reset and in the first cycle after it
      if (trigger !== 1'b0) begin
        $display("[ERROR] %0d ns trigger: got %b expected 0", $time, trigger);
        reset_errors++;
      end
      if (usb_isout !== 1'b0) begin
        $display("[ERROR] %0d ns usb_isout: got %b expected 0", $time, usb_isout);
        reset_errors++;
      end
    end else if (trigger === 1'b1) begin
      trig_total++;
    end
  end

  task automatic start_row();
    trig_base = trig_total;
    err_base  = check_errors;
  endtask

  // Called in the last cycle of a host read
  task automatic check_dout(input string what, input logic [7:0] exp);
    if (usb_isout !== 1'b1) begin
      $display("[ERROR] %0d ns usb_isout: got %b expected 1 (%s)", $time, usb_isout, what);
      check_errors++;
    end
    if (usb_dout !== exp) begin
      $display("[ERROR] %0d ns usb_dout: got %h expected %h (%s)", $time, usb_dout, exp, what);
      check_errors++;
    end
  endtask

  task automatic finish_row(input string name, input int exp_pulses);
    int got;
    got = trig_total - trig_base;
    if (got != exp_pulses) begin
      $display("[ERROR] %0d ns trigger: got %0d pulses expected %0d", $time, got, exp_pulses);
      check_errors++;
    end
    rows_run++;
    if (check_errors == err_base) begin
      $display("test %0d %s: ok", rows_run, name);
    end else begin
      rows_failed++;
      $display("test %0d %s: %0d errors", rows_run, name, check_errors - err_base);
    end
  endtask

  task automatic report();
    $display("Summary: %0d tests, %0d failed, %0d errors", rows_run, rows_failed, error_count);
  endtask

endmodule

`default_nettype wire

// File: hdl/sad_trigger_top.sv
`default_nettype none

module sad_trigger_top (
  input  logic                            clk_usb,
  input  logic                            rst,
  input  logic [7:0]                      usb_addr,
  input  logic [7:0]                      usb_din,
  input  logic                            usb_rdn,
  input  logic                            usb_wrn,
  input  logic                            usb_cen,
  input  logic                            usb_alen,
  input  logic [sad_pkg::sample_bits-1:0] adc_data,
  input  logic                            sample_strobe,
  input  logic                            arm,
  output logic [7:0]                      usb_dout,
  output logic                            usb_isout,
  output logic                            trigger
);

  // Register bus
  logic [7:0]                      reg_address;
  logic [sad_pkg::bytecnt_bits-1:0] reg_bytecnt;
  logic [7:0]                      reg_wdata;
  logic [7:0]                      reg_rdata;
  logic                            reg_read;
  logic                            reg_write;

  // Settings to the engine and status back
  logic [sad_pkg::ref_samples*sad_pkg::sample_bits-1:0] ref_flat;
  logic [sad_pkg::sad_bits-1:0]                         threshold;
  logic                                                 armed;
  logic                                                 triggered;

  usb_reg_bus u_usb_reg_bus (
    .clk_usb     (clk_usb),
    .rst         (rst),
    .usb_addr    (usb_addr),
    .usb_din     (usb_din),
    .usb_rdn     (usb_rdn),
    .usb_wrn     (usb_wrn),
    .usb_cen     (usb_cen),
    .usb_alen    (usb_alen),
    .reg_rdata   (reg_rdata),
    .usb_dout    (usb_dout),
    .usb_isout   (usb_isout),
    .reg_address (reg_address),
    .reg_bytecnt (reg_bytecnt),
    .reg_wdata   (reg_wdata),
    .reg_read    (reg_read),
    .reg_write   (reg_write)
  );

  sad_ref_regs u_sad_ref_regs (
    .clk_usb     (clk_usb),
    .rst         (rst),
    .reg_address (reg_address),
    .reg_bytecnt (reg_bytecnt),
    .reg_wdata   (reg_wdata),
    .reg_write   (reg_write),
    .reg_read    (reg_read),
    .armed       (armed),
    .triggered   (triggered),
    .reg_rdata   (reg_rdata),
    .ref_flat    (ref_flat),
    .threshold   (threshold)
  );

  sad_engine u_sad_engine (
    .clk_usb       (clk_usb),
    .rst           (rst),
    .adc_data      (adc_data),
    .sample_strobe (sample_strobe),
    .arm           (arm),
    .ref_flat      (ref_flat),
    .threshold     (threshold),
    .trigger       (trigger),
    .armed         (armed),
    .triggered     (triggered)
  );

endmodule

`default_nettype wire

// File: sad/sad_engine.sv
`default_nettype none

module sad_engine (
  input  logic                                                  clk_usb,
  input  logic                                                  rst,
  input  logic [sad_pkg::sample_bits-1:0]                       adc_data,
  input  logic                                                  sample_strobe,
  input  logic                                                  arm,
  input  logic [sad_pkg::ref_samples*sad_pkg::sample_bits-1:0]  ref_flat,
  input  logic [sad_pkg::sad_bits-1:0]                          threshold,
  output logic                                                  trigger,
  output logic                                                  armed,
  output logic                                                  triggered
);

  // Sliding window, newest sample at the top index
  logic [sad_pkg::sample_bits-1:0] window [sad_pkg::ref_samples];

  // Fills since arming, saturates at a full window
  logic [sad_pkg::fill_bits-1:0] fill;

  // Arm edge detect
  logic arm_q;
  logic arm_rise;

  // Strobe delayed to line up with the shifted window
  logic strobe_d;

  // Combinational sum and its registered copy
  logic [sad_pkg::sad_bits-1:0] sad_sum;
  logic [sad_pkg::sad_bits-1:0] sad_q;
  logic                         sad_valid;

  // Trigger condition
  logic fire;

  assign arm_rise = arm & ~arm_q;

  // Shift in each strobed sample
  always_ff @(posedge clk_usb) begin
    if (sample_strobe) begin
      for (int i = 0; i < sad_pkg::ref_samples - 1; i++) begin
        window[i] <= window[i+1];
      end
      window[sad_pkg::ref_samples-1] <= adc_data;
    end
  end

  // Sum of absolute differences over the current window
  always_comb begin
    logic [sad_pkg::sample_bits-1:0] w;
    logic [sad_pkg::sample_bits-1:0] r;
    sad_sum = '0;
    for (int i = 0; i < sad_pkg::ref_samples; i++) begin
      w = window[i];
      r = ref_flat[i*sad_pkg::sample_bits +: sad_pkg::sample_bits];
      // Larger minus smaller keeps the difference unsigned
      sad_sum = sad_sum + ((w > r) ? sad_pkg::sad_bits'(w - r) : sad_pkg::sad_bits'(r - w));
    end
  end

  // Registered result, valid only for a full window
  always_ff @(posedge clk_usb) begin
    sad_q <= sad_sum;
  end

  assign fire = armed & sad_valid & (sad_q <= threshold);

  // Control: arming, fill count, result valid and trigger
  always_ff @(posedge clk_usb) begin
    if (rst) begin
      arm_q     <= 1'b0;
      fill      <= '0;
      strobe_d  <= 1'b0;
      sad_valid <= 1'b0;
      armed     <= 1'b0;
      triggered <= 1'b0;
      trigger   <= 1'b0;
    end else begin
      arm_q <= arm;
      if (arm_rise) begin
        // Restart filling, drop results still in flight
        armed     <= 1'b1;
        triggered <= 1'b0;
        fill      <= '0;
        strobe_d  <= 1'b0;
        sad_valid <= 1'b0;
        trigger   <= 1'b0;
      end else begin
        strobe_d  <= sample_strobe;
        if (sample_strobe && fill != sad_pkg::ref_samples) begin
          fill <= fill + 1'b1;
        end
        sad_valid <= strobe_d && (fill == sad_pkg::ref_samples);
        trigger   <= fire;
        if (fire) begin
          // Single shot until the next arm
          armed     <= 1'b0;
          triggered <= 1'b1;
        end
      end
    end
  end

  // Trigger is a single cycle pulse
  a_trig_pulse: assert property (
    @(posedge clk_usb) disable iff (rst) trigger |=> !trigger
  );

  // Trigger only follows an armed cycle
  a_trig_armed: assert property (
    @(posedge clk_usb) disable iff (rst) trigger |-> $past(armed)
  );

endmodule

`default_nettype wire

// File: sad/sad_ref_regs.sv
`default_nettype none

module sad_ref_regs (
  input  logic                                                  clk_usb,
  input  logic                                                  rst,
  input  logic [7:0]                                            reg_address,
  input  logic [sad_pkg::bytecnt_bits-1:0]                      reg_bytecnt,
  input  logic [7:0]                                            reg_wdata,
  input  logic                                                  reg_write,
  input  logic                                                  reg_read,
  input  logic                                                  armed,
  input  logic                                                  triggered,
  output logic [7:0]                                            reg_rdata,
  output logic [sad_pkg::ref_samples*sad_pkg::sample_bits-1:0]  ref_flat,
  output logic [sad_pkg::sad_bits-1:0]                          threshold
);

  // Reference sample words
  sad_pkg::sample_word_t ref_words [sad_pkg::ref_samples];

  // Byte index decode, two bytes per sample
  logic [2:0] ref_idx;
  logic       ref_hi;
  logic       ref_in_range;

  assign ref_idx      = reg_bytecnt[3:1];
  assign ref_hi       = reg_bytecnt[0];
  // Bytes past the last sample are ignored
  assign ref_in_range = (reg_bytecnt < 2 * sad_pkg::ref_samples);

  // Register writes, low byte first
  always_ff @(posedge clk_usb) begin
    if (rst) begin
      for (int i = 0; i < sad_pkg::ref_samples; i++) begin
        ref_words[i] <= '0;
      end
      threshold <= '0;
    end else if (reg_write) begin
      case (reg_address)
        sad_pkg::reg_addr_ref: begin
          if (ref_in_range && ref_hi) begin
            // Pad bits stay clear
            ref_words[ref_idx].bytes.hi <= {{sad_pkg::pad_bits{1'b0}},
                                            reg_wdata[7-sad_pkg::pad_bits:0]};
          end else if (ref_in_range) begin
            ref_words[ref_idx].bytes.lo <= reg_wdata;
          end
        end
        sad_pkg::reg_addr_threshold: begin
          if (reg_bytecnt[0]) threshold[15:8] <= reg_wdata;
          else threshold[7:0] <= reg_wdata;
        end
        // Status and unknown addresses take no writes
        default: ;
      endcase
    end
  end

  // Readback from the byte view, valid during the read pulse
  always_comb begin
    reg_rdata = 8'h00;
    if (reg_read) begin
      case (reg_address)
        sad_pkg::reg_addr_ref: begin
          if (ref_in_range) begin
            reg_rdata = ref_hi ? ref_words[ref_idx].bytes.hi : ref_words[ref_idx].bytes.lo;
          end
        end
        sad_pkg::reg_addr_threshold: begin
          reg_rdata = reg_bytecnt[0] ? threshold[15:8] : threshold[7:0];
        end
        sad_pkg::reg_addr_status: begin
          reg_rdata = {6'b0, triggered, armed};
        end
        default: reg_rdata = 8'h00;
      endcase
    end
  end

  // Engine sees the sample view, sample 0 in the low bits
  always_comb begin
    for (int i = 0; i < sad_pkg::ref_samples; i++) begin
      ref_flat[i*sad_pkg::sample_bits +: sad_pkg::sample_bits] = ref_words[i].smp.sample;
    end
  end

  // Status is read only, stored settings hold across such a write
  a_status_ro: assert property (
    @(posedge clk_usb) disable iff (rst)
    (reg_write && reg_address == sad_pkg::reg_addr_status)
      |=> ($stable(ref_flat) && $stable(threshold))
  );

endmodule

`default_nettype wire

// File: hdl/usb_reg_bus.sv
`default_nettype none

module usb_reg_bus (
  input  logic                            clk_usb,
  input  logic                            rst,
  input  logic [7:0]                      usb_addr,
  input  logic [7:0]                      usb_din,
  input  logic                            usb_rdn,
  input  logic                            usb_wrn,
  input  logic                            usb_cen,
  input  logic                            usb_alen,
  input  logic [7:0]                      reg_rdata,
  output logic [7:0]                      usb_dout,
  output logic                            usb_isout,
  output logic [7:0]                      reg_address,
  output logic [sad_pkg::bytecnt_bits-1:0] reg_bytecnt,
  output logic [7:0]                      reg_wdata,
  output logic                            reg_read,
  output logic                            reg_write
);

  // Sampled host strobes, idle high
  logic rdn_q;
  logic wrn_q;
  logic cen_q;

  // One cycle older copies for edge detection
  logic rdn_qq;
  logic wrn_qq;

  // Strobe sampling, reset to the idle level
  always_ff @(posedge clk_usb) begin
    if (rst) begin
      rdn_q  <= 1'b1;
      wrn_q  <= 1'b1;
      cen_q  <= 1'b1;
      rdn_qq <= 1'b1;
      wrn_qq <= 1'b1;
    end else begin
      rdn_q  <= usb_rdn;
      wrn_q  <= usb_wrn;
      cen_q  <= usb_cen;
      rdn_qq <= rdn_q;
      wrn_qq <= wrn_q;
    end
  end

  // Write data follows the sampled strobes
  always_ff @(posedge clk_usb) begin
    reg_wdata <= usb_din;
  end

  // Falling strobe edge while selected gives one access pulse
  assign reg_read  = rdn_qq & ~rdn_q & ~cen_q;
  assign reg_write = wrn_qq & ~wrn_q & ~cen_q;

  // Drive the data bus for as long as the host reads
  assign usb_isout = ~rdn_q & ~cen_q;

  // Address latch and auto increment byte counter
  always_ff @(posedge clk_usb) begin
    if (rst) begin
      reg_address <= 8'h00;
      reg_bytecnt <= '0;
    end else if (!usb_alen) begin
      // New address starts a new burst
      reg_address <= usb_addr;
      reg_bytecnt <= '0;
    end else if (reg_read || reg_write) begin
      reg_bytecnt <= reg_bytecnt + 1'b1;
    end
  end

  // Capture readback while the byte count still points at this byte
  always_ff @(posedge clk_usb) begin
    if (reg_read) begin
      usb_dout <= reg_rdata;
    end
  end

  // Host never reads and writes in the same cycle
  a_no_rw_overlap: assert property (
    @(posedge clk_usb) disable iff (rst) !(reg_read && reg_write)
  );

endmodule

`default_nettype wire

// File: common/sad_pkg.sv
`default_nettype none

package sad_pkg;

  // Window length and ADC sample width
  localparam int ref_samples = 8;
  localparam int sample_bits = 12;

  // SAD sum and threshold width, enough for 8 x 4095
  localparam int sad_bits = 16;

  // Host byte counter width
  localparam int bytecnt_bits = 7;

  // Unused upper bits of a 16-bit sample word
  localparam int pad_bits = 16 - sample_bits;

  // Fill counter runs 0 to ref_samples
  localparam int fill_bits = $clog2(ref_samples + 1);

  // Register map
  localparam logic [7:0] reg_addr_ref       = 8'd1;
  localparam logic [7:0] reg_addr_threshold = 8'd2;
  // Read only, bit 0 armed, bit 1 triggered
  localparam logic [7:0] reg_addr_status    = 8'd3;

  // One reference sample word
  // Host side sees two bytes, engine side sees the padded sample
  typedef union packed {
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } bytes;
    struct packed {
      logic [pad_bits-1:0]    pad;
      logic [sample_bits-1:0] sample;
    } smp;
  } sample_word_t;

endpackage

`default_nettype wire
